// ==== dv/w5500_stimulus.txt ====
// Hex words for $readmemh. @00 expected init frames {addr, ctl, data} in step order
// @20 socket status replies ending with 22, @28 pairs of payload and push frame {ptr, 14, payload}
@00
002E04D8 000904AA 000A04AF 000B04FA 000C04CC 000D04E3 000E041C 000F04C0
001004A8 0011040A 001204C2 000104C0 000204A8 0003040A 00040401 000504FF
000604FF 000704FF 00080400 00000C02 001E0C10 001F0C10 00040C09 00050C56
00010C01 000C0CC0 000D0CA8 000E0C0A 000F0C14 00100C13 00110C88
// Closed, init, closed, then UDP open
@20
00 13 00 22
// Transmissions at pointers 0, 8 and 16
@28
0123456789ABCDEF 0000140123456789ABCDEF
DEADBEEFCAFEF00D 000814DEADBEEFCAFEF00D
55AA33CC0F0FF0F0 00101455AA33CC0F0FF0F0

// ==== w5500_udp_tx.f ====
hdl/w5500_reg_pkg.sv
hdl/w5500_net_pkg.sv
hdl/w5500_spi_master.sv
hdl/w5500_init_table.sv
hdl/w5500_sequencer.sv
hdl/w5500_udp_tx.sv
dv/tb_clock_gen.sv
dv/w5500_udp_tx_tb.sv

// ==== Bender.yml ====
package:
  name: w5500_udp_tx

sources:
  - files:
      - hdl/w5500_reg_pkg.sv
      - hdl/w5500_net_pkg.sv
      - hdl/w5500_spi_master.sv
      - hdl/w5500_init_table.sv
      - hdl/w5500_sequencer.sv
      - hdl/w5500_udp_tx.sv
  - target: test
    files:
      - dv/tb_clock_gen.sv
      - dv/w5500_udp_tx_tb.sv

// ==== dv/w5500_udp_tx_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module w5500_udp_tx_tb;
    localparam int PAYLOAD_BITS = 64;
    localparam int INIT_STEPS   = 31;
    localparam int REPLY_BASE   = 'h20;
    localparam int TX_BASE      = 'h28;
    localparam int WAIT_LIMIT   = 20000;
    localparam logic [23:0] STATUS_HDR = w5500_reg_pkg::CMD_READ_S0_STATUS[31:8];
    // S0 TX write pointer, high byte at 0x0024 and low byte at 0x0025
    localparam logic [23:0] PTR_LO_HDR = 24'h00_25_0C;
    localparam logic [23:0] PTR_HI_HDR = 24'h00_24_0C;

    logic                    clk;
    logic                    rst;
    logic                    tx_start;
    logic [PAYLOAD_BITS-1:0] tx_payload;
    logic                    ready;
    logic                    sclk;
    logic                    mosi;
    logic                    cs_n;
    logic                    miso;

    logic [95:0] stim [0:63];
    logic [95:0] frames [$];
    int          frame_bits [$];
    logic [95:0] rx_shift;
    int          rx_bits;
    logic        is_status;
    int          reply_idx;
    int          n_replies;
    logic [7:0]  current_reply;

    int          errors;
    int          tests_run;
    int          tests_failed;
    bit          timed_out;
    logic [31:0] lcg_state;
    logic [15:0] exp_ptr;

    tb_clock_gen #(.PERIOD_NS(20)) tb_clock_gen_inst (.clk(clk));

    w5500_udp_tx #(.PAYLOAD_BITS(PAYLOAD_BITS)) w5500_udp_tx_inst (
        .clk        (clk),
        .rst        (rst),
        .tx_start   (tx_start),
        .tx_payload (tx_payload),
        .ready      (ready),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_n       (cs_n),
        .miso       (miso)
    );

    // SPI slave model, one frame per cs_n low period
    always @(negedge cs_n) begin
        rx_shift  = '0;
        rx_bits   = 0;
        is_status = 1'b0;
    end

    always @(posedge sclk) begin
        if (!cs_n) begin
            rx_shift = {rx_shift[94:0], mosi};
            rx_bits  = rx_bits + 1;
            if (rx_bits == 24) begin
                is_status = (rx_shift[23:0] == STATUS_HDR);
            end
        end
    end

    always @(posedge cs_n) begin
        if (rx_bits > 0) begin
            frames.push_back(rx_shift);
            frame_bits.push_back(rx_bits);
            if (is_status && rx_bits == 32) begin
                reply_idx = reply_idx + 1;
                // Last reply (socket open) repeats once the list runs out
                if (reply_idx < n_replies) begin
                    current_reply = stim[REPLY_BASE + reply_idx][7:0];
                end
            end
            rx_bits = 0;
        end
    end

    // Data phase of a status read returns the current reply, MSB first
    always @(negedge clk) begin
        if (!cs_n && is_status && rx_bits >= 24 && rx_bits < 32) begin
            miso = current_reply[31 - rx_bits];
        end else begin
            miso = 1'b0;
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic compare(input string name, input logic [95:0] got,
                           input logic [95:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        tests_run++;
        if (timed_out || errors != err_start) begin
            tests_failed++;
            $display("test %s: FAILED", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    task automatic wait_frames(input int count, input string what);
        int cycles;
        cycles = 0;
        while (frames.size() < count && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (frames.size() < count) begin
            $display("Timeout during %s: only %0d of %0d SPI frames seen",
                     what, frames.size(), count);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        while (ready !== 1'b1 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (ready !== 1'b1) begin
            $display("Timeout during %s: ready never went high", what);
            timed_out = 1'b1;
        end
    endtask

    // Observation window in which no SPI frame may start
    task automatic idle_window(input string what);
        int count_before;
        int gap;
        count_before = frames.size();
        lcg_state    = next_random(lcg_state);
        gap          = 100 + (lcg_state[23:16] % 64);
        repeat (gap) begin
            @(negedge clk);
            compare({what, " cs_n"}, cs_n, 1'b1);
        end
        compare({what, " frame_count"}, frames.size(), count_before);
    endtask

    task automatic transmit(input int t, input bit extra_start);
        int                      base;
        logic [PAYLOAD_BITS-1:0] payload;
        logic [95:0]             f;
        base    = frames.size();
        payload = stim[TX_BASE + 2 * t][PAYLOAD_BITS-1:0];
        tx_payload = payload;
        tx_start   = 1'b1;
        @(negedge clk);
        tx_start   = 1'b0;
        // Payload must already be captured
        tx_payload = ~payload;
        compare("ready", ready, 1'b0);
        if (extra_start) begin
            repeat (40) @(negedge clk);
            tx_start = 1'b1;
            @(negedge clk);
            tx_start = 1'b0;
        end
        wait_ready("transmit");
        if (timed_out) begin
            return;
        end
        compare("frame_count", frames.size(), base + 4);
        if (frames.size() >= base + 4) begin
            f = frames[base];
            compare("push_frame", f, stim[TX_BASE + 2 * t + 1]);
            compare("push_bits", frame_bits[base], 24 + PAYLOAD_BITS);
            compare("push_ptr", f[PAYLOAD_BITS+23 -: 16], exp_ptr);
            compare("ptr_lo_frame", frames[base + 1], {PTR_LO_HDR, exp_ptr[7:0]});
            compare("ptr_hi_frame", frames[base + 2], {PTR_HI_HDR, exp_ptr[15:8]});
            compare("send_frame", frames[base + 3], w5500_reg_pkg::CMD_SEND_S0);
        end
        exp_ptr = exp_ptr + 16'(PAYLOAD_BITS / 8);
    endtask

    initial begin
        int err_start;
        rst        = 1'b1;
        tx_start   = 1'b0;
        tx_payload = '0;
        miso       = 1'b0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        timed_out    = 1'b0;
        lcg_state    = 32'h8555_30b2;
        exp_ptr      = '0;
        reply_idx    = 0;
        $readmemh("dv/w5500_stimulus.txt", stim);
        n_replies = 0;
        while (n_replies < 8 &&
               stim[REPLY_BASE + n_replies][7:0] !== w5500_reg_pkg::SOCK_UDP_OPEN) begin
            n_replies++;
        end
        n_replies++;
        current_reply = stim[REPLY_BASE][7:0];

        err_start = errors;
        repeat (8) begin
            @(negedge clk);
            compare("ready", ready, 1'b0);
            compare("cs_n", cs_n, 1'b1);
            compare("sclk", sclk, 1'b0);
        end
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            compare("ready", ready, 1'b0);
        end
        report_test("reset", err_start);

        // A start during init is ignored
        err_start  = errors;
        tx_payload = 64'hFFFF_0000_FFFF_0000;
        tx_start   = 1'b1;
        @(negedge clk);
        tx_start = 1'b0;
        wait_frames(INIT_STEPS, "init sequence");
        if (!timed_out) begin
            for (int i = 0; i < INIT_STEPS; i++) begin
                compare($sformatf("init_frame[%0d]", i), frames[i], stim[i]);
                compare($sformatf("init_bits[%0d]", i), frame_bits[i], 32);
            end
        end
        report_test("init_sequence", err_start);

        if (!timed_out) begin
            err_start = errors;
            wait_ready("socket status polling");
            if (!timed_out) begin
                compare("frame_count", frames.size(), INIT_STEPS + n_replies);
                for (int i = INIT_STEPS; i < frames.size(); i++) begin
                    compare($sformatf("status_frame[%0d]", i), frames[i],
                            w5500_reg_pkg::CMD_READ_S0_STATUS);
                end
                idle_window("idle");
                compare("ready", ready, 1'b1);
            end
            report_test("status_poll", err_start);
        end

        if (!timed_out) begin
            err_start = errors;
            transmit(0, 1'b0);
            report_test("first_transmit", err_start);
        end

        if (!timed_out) begin
            err_start = errors;
            transmit(1, 1'b0);
            report_test("pointer_advance", err_start);
        end

        if (!timed_out) begin
            err_start = errors;
            transmit(2, 1'b1);
            if (!timed_out) begin
                idle_window("after ignored start");
            end
            report_test("ignored_start", err_start);
        end

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2);
        clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== hdl/w5500_udp_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module w5500_udp_tx #(
    parameter w5500_net_pkg::ip_addr_t  LOCAL_IP     = {8'd192, 8'd168, 8'd10, 8'd194},
    parameter w5500_net_pkg::mac_addr_t MAC_ADDR     = 48'hAA_AF_FA_CC_E3_1C,
    parameter w5500_net_pkg::udp_port_t SRC_PORT     = 16'd2390,
    parameter w5500_net_pkg::ip_addr_t  DST_IP       = {8'd192, 8'd168, 8'd10, 8'd20},
    parameter w5500_net_pkg::udp_port_t DST_PORT     = 16'd5000,
    parameter int                       PAYLOAD_BITS = 64,
    parameter int                       SCLK_HALF    = 2
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    tx_start,
    input  logic [PAYLOAD_BITS-1:0] tx_payload,
    output logic                    ready,
    output logic                    sclk,
    output logic                    mosi,
    output logic                    cs_n,
    input  logic                    miso
);
    w5500_net_pkg::net_cfg_t  net_cfg;
    w5500_net_pkg::spi_req_t  req;
    w5500_net_pkg::spi_cmd_t  init_cmd;
    w5500_net_pkg::init_idx_t init_idx;
    w5500_net_pkg::byte_t     rd_byte;
    logic                     frame_done;

    assign net_cfg = '{
        local_ip: LOCAL_IP,
        mac:      MAC_ADDR,
        src_port: SRC_PORT,
        dst_ip:   DST_IP,
        dst_port: DST_PORT
    };

    w5500_sequencer #(
        .PAYLOAD_BITS (PAYLOAD_BITS)
    ) w5500_sequencer_inst (
        .clk        (clk),
        .rst        (rst),
        .tx_start   (tx_start),
        .init_cmd   (init_cmd),
        .frame_done (frame_done),
        .rd_byte    (rd_byte),
        .init_idx   (init_idx),
        .req        (req),
        .ready      (ready)
    );

    w5500_init_table w5500_init_table_inst (
        .idx (init_idx),
        .cfg (net_cfg),
        .cmd (init_cmd)
    );

    w5500_spi_master #(
        .PAYLOAD_BITS (PAYLOAD_BITS),
        .SCLK_HALF    (SCLK_HALF)
    ) w5500_spi_master_inst (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .payload    (tx_payload),
        .miso       (miso),
        .sclk       (sclk),
        .mosi       (mosi),
        .cs_n       (cs_n),
        .frame_done (frame_done),
        .rd_byte    (rd_byte)
    );

endmodule

`default_nettype wire

// ==== hdl/w5500_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module w5500_sequencer #(
    parameter int PAYLOAD_BITS = 64
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      tx_start,
    input  w5500_net_pkg::spi_cmd_t   init_cmd,
    input  logic                      frame_done,
    input  w5500_net_pkg::byte_t      rd_byte,
    output w5500_net_pkg::init_idx_t  init_idx,
    output w5500_net_pkg::spi_req_t   req,
    output logic                      ready
);
    typedef enum logic [3:0] {
        INIT_ISSUE,
        INIT_WAIT,
        POLL_ISSUE,
        POLL_WAIT,
        IDLE,
        PUSH,
        PTR_LO,
        PTR_HI,
        SEND
    } state_t;

    localparam w5500_net_pkg::tx_ptr_t PTR_STEP =
        w5500_net_pkg::tx_ptr_t'(PAYLOAD_BITS / 8);
    localparam w5500_net_pkg::init_idx_t LAST_STEP =
        w5500_net_pkg::init_idx_t'(w5500_reg_pkg::INIT_STEPS - 1);

    state_t                 state;
    state_t                 state_next;
    w5500_net_pkg::tx_ptr_t tx_ptr;

    // Requests go out in the same cycle as the decision, so the
    // master latches tx_payload in the tx_start cycle
    always_comb begin
        state_next = state;
        req.start  = 1'b0;
        req.kind   = w5500_net_pkg::SPI_CMD;
        req.cmd    = init_cmd;
        req.ptr    = tx_ptr;
        case (state)
            INIT_ISSUE: begin
                req.start  = 1'b1;
                state_next = INIT_WAIT;
            end
            INIT_WAIT: begin
                if (frame_done) begin
                    state_next = (init_idx == LAST_STEP) ? POLL_ISSUE : INIT_ISSUE;
                end
            end
            POLL_ISSUE: begin
                req.start  = 1'b1;
                req.cmd    = w5500_reg_pkg::CMD_READ_S0_STATUS;
                state_next = POLL_WAIT;
            end
            POLL_WAIT: begin
                if (frame_done) begin
                    state_next = (rd_byte == w5500_reg_pkg::SOCK_UDP_OPEN) ? IDLE : POLL_ISSUE;
                end
            end
            IDLE: begin
                if (tx_start) begin
                    req.start  = 1'b1;
                    req.kind   = w5500_net_pkg::SPI_DATA;
                    state_next = PUSH;
                end
            end
            PUSH: begin
                if (frame_done) begin
                    req.start  = 1'b1;
                    req.cmd    = {w5500_reg_pkg::ADDR_S0_TX_WR + 16'd1,
                                  w5500_reg_pkg::CTL_WRITE_S0, tx_ptr[7:0]};
                    state_next = PTR_LO;
                end
            end
            PTR_LO: begin
                if (frame_done) begin
                    req.start  = 1'b1;
                    req.cmd    = {w5500_reg_pkg::ADDR_S0_TX_WR,
                                  w5500_reg_pkg::CTL_WRITE_S0, tx_ptr[15:8]};
                    state_next = PTR_HI;
                end
            end
            PTR_HI: begin
                if (frame_done) begin
                    req.start  = 1'b1;
                    req.cmd    = w5500_reg_pkg::CMD_SEND_S0;
                    state_next = SEND;
                end
            end
            SEND: begin
                if (frame_done) begin
                    state_next = IDLE;
                end
            end
            default: state_next = INIT_ISSUE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= INIT_ISSUE;
            init_idx <= '0;
            tx_ptr   <= '0;
            ready    <= 1'b0;
        end else begin
            state <= state_next;
            // Raised when the socket opens or a SEND completes
            if (frame_done && (state == SEND || (state == POLL_WAIT &&
                    rd_byte == w5500_reg_pkg::SOCK_UDP_OPEN))) begin
                ready <= 1'b1;
            end else if (state == IDLE && tx_start) begin
                ready <= 1'b0;
            end
            if (state == INIT_WAIT && frame_done && init_idx != LAST_STEP) begin
                init_idx <= init_idx + 1'b1;
            end
            // Next packet lands behind this one in the TX buffer
            if (state == SEND && frame_done) begin
                tx_ptr <= tx_ptr + PTR_STEP;
            end
        end
    end

    a_ready_idle: assert property (@(posedge clk) disable iff (rst) ready |-> state == IDLE);

endmodule

`default_nettype wire

// ==== hdl/w5500_init_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module w5500_init_table (
    input  w5500_net_pkg::init_idx_t idx,
    input  w5500_net_pkg::net_cfg_t  cfg,
    output w5500_net_pkg::spi_cmd_t  cmd
);
    logic [15:0]          addr;
    logic [7:0]           ctl;
    w5500_net_pkg::byte_t data;
    logic [2:0]           k;

    always_comb begin
        addr = 16'h0000;
        ctl  = w5500_reg_pkg::CTL_WRITE_REG;
        data = 8'h00;
        k    = 3'd0;
        case (idx) inside
            5'd0: {addr, ctl, data} = w5500_reg_pkg::CMD_PHY_MODE;
            [5'd1:5'd6]: begin
                k    = 3'(idx - 5'd1);
                addr = w5500_reg_pkg::ADDR_SHAR + 16'(k);
                data = cfg.mac[8*(5-k) +: 8];
            end
            [5'd7:5'd10]: begin
                k    = 3'(idx - 5'd7);
                addr = w5500_reg_pkg::ADDR_SIPR + 16'(k);
                data = cfg.local_ip[8*(3-k) +: 8];
            end
            [5'd11:5'd14]: begin
                k    = 3'(idx - 5'd11);
                addr = w5500_reg_pkg::ADDR_GAR + 16'(k);
                data = w5500_reg_pkg::GATEWAY_IP[8*(3-k) +: 8];
            end
            [5'd15:5'd18]: begin
                k    = 3'(idx - 5'd15);
                addr = w5500_reg_pkg::ADDR_SUBR + 16'(k);
                data = w5500_reg_pkg::SUBNET_MASK[8*(3-k) +: 8];
            end
            5'd19: begin
                addr = w5500_reg_pkg::ADDR_S0_MR;
                ctl  = w5500_reg_pkg::CTL_WRITE_S0;
                data = w5500_reg_pkg::S0_MODE_UDP;
            end
            5'd20, 5'd21: begin
                addr = (idx == 5'd20) ? w5500_reg_pkg::ADDR_S0_RXBUF_SIZE :
                                        w5500_reg_pkg::ADDR_S0_TXBUF_SIZE;
                ctl  = w5500_reg_pkg::CTL_WRITE_S0;
                data = w5500_reg_pkg::S0_BUF_KB;
            end
            [5'd22:5'd23]: begin
                k    = 3'(idx - 5'd22);
                addr = w5500_reg_pkg::ADDR_S0_PORT + 16'(k);
                ctl  = w5500_reg_pkg::CTL_WRITE_S0;
                data = cfg.src_port[8*(1-k) +: 8];
            end
            5'd24: {addr, ctl, data} = w5500_reg_pkg::CMD_OPEN_S0;
            [5'd25:5'd28]: begin
                k    = 3'(idx - 5'd25);
                addr = w5500_reg_pkg::ADDR_S0_DIPR + 16'(k);
                ctl  = w5500_reg_pkg::CTL_WRITE_S0;
                data = cfg.dst_ip[8*(3-k) +: 8];
            end
            [5'd29:5'd30]: begin
                k    = 3'(idx - 5'd29);
                addr = w5500_reg_pkg::ADDR_S0_DPORT + 16'(k);
                ctl  = w5500_reg_pkg::CTL_WRITE_S0;
                data = cfg.dst_port[8*(1-k) +: 8];
            end
            default: ;
        endcase
        cmd = {addr, ctl, data};
    end

endmodule

`default_nettype wire

// ==== hdl/w5500_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module w5500_spi_master #(
    parameter int PAYLOAD_BITS = 64,
    parameter int SCLK_HALF    = 2
) (
    input  logic                     clk,
    input  logic                     rst,
    input  w5500_net_pkg::spi_req_t  req,
    input  logic [PAYLOAD_BITS-1:0]  payload,
    input  logic                     miso,
    output logic                     sclk,
    output logic                     mosi,
    output logic                     cs_n,
    output logic                     frame_done,
    output w5500_net_pkg::byte_t     rd_byte
);
    localparam int CMD_BITS  = 32;
    localparam int DATA_BITS = 24 + PAYLOAD_BITS;
    localparam int SHIFT_W   = (DATA_BITS > CMD_BITS) ? DATA_BITS : CMD_BITS;
    localparam int BIT_W     = $clog2(SHIFT_W + 1);
    localparam int HALF_W    = $clog2(SCLK_HALF + 1);

    logic [SHIFT_W-1:0]       shift_q;
    logic [BIT_W-1:0]         bits_left;
    logic [HALF_W-1:0]        half_cnt;
    logic                     busy;
    logic                     tail;
    logic                     half_done;
    w5500_net_pkg::spi_kind_t kind_q;

    assign half_done = busy && (half_cnt == HALF_W'(SCLK_HALF - 1));
    assign mosi      = shift_q[SHIFT_W-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            tail       <= 1'b0;
            sclk       <= 1'b0;
            cs_n       <= 1'b1;
            half_cnt   <= '0;
            bits_left  <= '0;
            kind_q     <= w5500_net_pkg::SPI_CMD;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (!busy) begin
                if (req.start) begin
                    busy      <= 1'b1;
                    cs_n      <= 1'b0;
                    half_cnt  <= '0;
                    kind_q    <= req.kind;
                    bits_left <= (req.kind == w5500_net_pkg::SPI_DATA) ?
                                 BIT_W'(DATA_BITS) : BIT_W'(CMD_BITS);
                end
            end else if (!half_done) begin
                half_cnt <= half_cnt + 1'b1;
            end else begin
                half_cnt <= '0;
                if (tail) begin
                    // cs_n released one half period after the last falling edge
                    tail       <= 1'b0;
                    busy       <= 1'b0;
                    cs_n       <= 1'b1;
                    frame_done <= 1'b1;
                end else if (!sclk) begin
                    sclk <= 1'b1;
                end else begin
                    sclk      <= 1'b0;
                    bits_left <= bits_left - 1'b1;
                    tail      <= (bits_left == BIT_W'(1));
                end
            end
        end
    end

    // Frame is left aligned, mosi moves on the falling edge
    always_ff @(posedge clk) begin
        if (!busy && req.start) begin
            if (req.kind == w5500_net_pkg::SPI_DATA) begin
                shift_q <= SHIFT_W'({req.ptr, w5500_reg_pkg::CTL_WRITE_S0_TXBUF, payload})
                           << (SHIFT_W - DATA_BITS);
            end else begin
                shift_q <= SHIFT_W'(req.cmd) << (SHIFT_W - CMD_BITS);
            end
        end else if (half_done && sclk && !tail) begin
            shift_q <= shift_q << 1;
        end
        if (half_done && !sclk && !tail && kind_q == w5500_net_pkg::SPI_CMD) begin
            rd_byte <= {rd_byte[6:0], miso};
        end
    end

    a_sclk_idle_low: assert property (@(posedge clk) disable iff (rst) cs_n |-> !sclk);

    // Sequencer must wait for frame_done before the next request
    a_no_start_busy: assert property (@(posedge clk) disable iff (rst) busy |-> !req.start);

endmodule

`default_nettype wire

// ==== hdl/w5500_net_pkg.sv ====
`default_nettype none

package w5500_net_pkg;

    typedef logic [31:0] ip_addr_t;
    typedef logic [47:0] mac_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] spi_cmd_t;
    typedef logic [15:0] tx_ptr_t;
    typedef logic [4:0]  init_idx_t;

    typedef struct packed {
        ip_addr_t  local_ip;
        mac_addr_t mac;
        udp_port_t src_port;
        ip_addr_t  dst_ip;
        udp_port_t dst_port;
    } net_cfg_t;

    typedef enum logic {SPI_CMD, SPI_DATA} spi_kind_t;

    // ptr is only shifted out by data frames
    typedef struct packed {
        logic      start;
        spi_kind_t kind;
        spi_cmd_t  cmd;
        tx_ptr_t   ptr;
    } spi_req_t;

endpackage

`default_nettype wire

// ==== hdl/w5500_reg_pkg.sv ====
`default_nettype none

package w5500_reg_pkg;

    // SPI control phase: block select, read/write bit, variable length mode
    localparam logic [7:0] CTL_WRITE_REG      = 8'h04;
    localparam logic [7:0] CTL_WRITE_S0       = 8'h0C;
    localparam logic [7:0] CTL_READ_S0        = 8'h08;
    localparam logic [7:0] CTL_WRITE_S0_TXBUF = 8'h14;

    // Common register block
    localparam logic [15:0] ADDR_GAR  = 16'h0001;
    localparam logic [15:0] ADDR_SUBR = 16'h0005;
    localparam logic [15:0] ADDR_SHAR = 16'h0009;
    localparam logic [15:0] ADDR_SIPR = 16'h000F;

    // Socket 0 register block
    localparam logic [15:0] ADDR_S0_MR         = 16'h0000;
    localparam logic [15:0] ADDR_S0_CR         = 16'h0001;
    localparam logic [15:0] ADDR_S0_SR         = 16'h0003;
    localparam logic [15:0] ADDR_S0_PORT       = 16'h0004;
    localparam logic [15:0] ADDR_S0_DIPR       = 16'h000C;
    localparam logic [15:0] ADDR_S0_DPORT      = 16'h0010;
    localparam logic [15:0] ADDR_S0_RXBUF_SIZE = 16'h001E;
    localparam logic [15:0] ADDR_S0_TXBUF_SIZE = 16'h001F;
    localparam logic [15:0] ADDR_S0_TX_WR      = 16'h0024;

    localparam logic [7:0]  S0_MODE_UDP   = 8'h02;
    localparam logic [7:0]  S0_BUF_KB     = 8'd16;
    localparam logic [7:0]  SOCK_UDP_OPEN = 8'h22;
    localparam logic [31:0] GATEWAY_IP    = {8'd192, 8'd168, 8'd10, 8'd1};
    localparam logic [31:0] SUBNET_MASK   = {8'd255, 8'd255, 8'd255, 8'd0};

    // 100 Mbit full duplex, no autonegotiation
    localparam logic [31:0] CMD_PHY_MODE       = 32'h002E04D8;
    localparam logic [31:0] CMD_OPEN_S0        = {ADDR_S0_CR, CTL_WRITE_S0, 8'h01};
    localparam logic [31:0] CMD_READ_S0_STATUS = {ADDR_S0_SR, CTL_READ_S0, 8'h00};
    localparam logic [31:0] CMD_SEND_S0        = {ADDR_S0_CR, CTL_WRITE_S0, 8'h20};

    localparam int INIT_STEPS = 31;

endpackage

`default_nettype wire
